//--- mv_pkg.sv
package mv_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    // largest matrix side and largest vector length
    localparam int DIM    = 16;

    // one row or column index
    localparam int IDX_W  = $clog2(DIM);

    // matrix address is {row, col}
    localparam int MAT_AW = 2 * IDX_W;

    localparam int ELEM_W = 8;

    // full product width plus log2 of the column count, so no wrap at 16x16
    localparam int ACC_W  = 2 * ELEM_W + IDX_W;

    //////////////////////////////////////////////////////////////////////
    // scalar types
    //////////////////////////////////////////////////////////////////////

    typedef logic        [IDX_W-1:0]  idx_t;
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    // job size, both counts given minus one
    typedef struct packed {
        idx_t rows_m1;
        idx_t cols_m1;
    } job_t;

    // one element pair on its way into the mac lane
    typedef struct packed {
        logic  valid;
        logic  last;
        idx_t  row;
        elem_t a;
        elem_t b;
    } mac_in_t;

endpackage

//--- agu_next.sv
`timescale 1ns/1ns

module agu_next (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_i,
    input  logic         en_i,
    input  mv_pkg::idx_t ini_i,
    input  mv_pkg::idx_t fin_i,
    output mv_pkg::idx_t data_o,
    output logic         next_o,
    output logic         last_o
);

    mv_pkg::idx_t idx_q;
    // final value kept so the job input may move after start
    mv_pkg::idx_t fin_q;

    // wrap point reached on an enabled cycle
    assign last_o = en_i & (idx_q == fin_q);
    assign next_o = en_i & ~last_o;
    assign data_o = idx_q;

    //////////////////////////////////////////////////////////////////////
    // index register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q <= '0;
            fin_q <= '0;
        end else if (start_i) begin
            // a start always wins, also mid loop
            idx_q <= ini_i;
            fin_q <= fin_i;
        end else if (last_o) begin
            idx_q <= ini_i;
        end else if (next_o) begin
            idx_q <= idx_q + 1'b1;
        end
    end

endmodule

//--- exe_ctrl.sv
`timescale 1ns/1ns

module exe_ctrl (
    input  logic         clk,
    input  logic         rst,
    input  logic         src_v_i,
    input  mv_pkg::job_t job_i,
    output mv_pkg::idx_t i_o,
    output mv_pkg::idx_t j_o,
    output logic         last_j_o,
    output logic         exec_o,
    output logic         k_fin_o,
    output logic         s_fin_o
);

    logic exec_q;
    logic k_fin_q;
    logic s_fin_q;
    logic last_j;
    logic last_i;
    // high from the cycle after last_i until its delayed copy
    logic fin_period_q;
    logic last_i_q;

    //////////////////////////////////////////////////////////////////////
    // loop counters
    //////////////////////////////////////////////////////////////////////

    // inner loop over columns, runs while exec is up
    agu_next col_cnt_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (src_v_i),
        .en_i    (exec_q),
        .ini_i   (mv_pkg::idx_t'(0)),
        .fin_i   (job_i.cols_m1),
        .data_o  (j_o),
        .next_o  (),
        .last_o  (last_j)
    );

    // outer loop over rows, steps once per finished row
    agu_next row_cnt_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (src_v_i),
        .en_i    (last_j),
        .ini_i   (mv_pkg::idx_t'(0)),
        .fin_i   (job_i.rows_m1),
        .data_o  (i_o),
        .next_o  (),
        .last_o  (last_i)
    );

    //////////////////////////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_q       <= 1'b0;
            k_fin_q      <= 1'b0;
            last_i_q     <= 1'b0;
            fin_period_q <= 1'b0;
            s_fin_q      <= 1'b0;
        end else begin
            // up the cycle after start, down after the final element
            exec_q   <= src_v_i | (exec_q & ~last_i);
            // row done, lines up with its last read data
            k_fin_q  <= last_j;
            last_i_q <= last_i;
            if (last_i) begin
                fin_period_q <= 1'b1;
            end else if (last_i_q) begin
                fin_period_q <= 1'b0;
            end
            // two cycles after last_i, final row sum written by then
            s_fin_q  <= fin_period_q & last_i_q;
        end
    end

    assign exec_o   = exec_q;
    assign k_fin_o  = k_fin_q;
    assign s_fin_o  = s_fin_q;
    assign last_j_o = last_j;

endmodule

//--- operand_ram.sv
`timescale 1ns/1ns

module operand_ram #(
    parameter type T  = mv_pkg::elem_t,
    parameter int  AW = 4
) (
    input  logic          clk,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  T              wdata_i,
    input  logic [AW-1:0] raddr_i,
    output T              rdata_o
);

    T mem_q [2**AW];
    T rdata_q;

    // one write and one read port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_q <= mem_q[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

//--- mac_lane.sv
`timescale 1ns/1ns

module mac_lane (
    input  logic            clk,
    input  logic            rst,
    input  mv_pkg::mac_in_t in_i,
    output logic            res_we_o,
    output mv_pkg::idx_t    res_addr_o,
    output mv_pkg::acc_t    res_data_o
);

    logic signed [2*mv_pkg::ELEM_W-1:0] prod;
    mv_pkg::acc_t prod_ext;
    mv_pkg::acc_t sum_nxt;
    mv_pkg::acc_t sum_q;
    // next valid element opens a new row
    logic         first_q;
    logic         we_q;
    mv_pkg::idx_t addr_q;
    mv_pkg::acc_t data_q;

    //////////////////////////////////////////////////////////////////////
    // multiply and add
    //////////////////////////////////////////////////////////////////////

    assign prod     = $signed(in_i.a) * $signed(in_i.b);
    assign prod_ext = mv_pkg::acc_t'(prod);
    // first column replaces the sum of the previous row
    assign sum_nxt  = first_q ? prod_ext : sum_q + prod_ext;

    always_ff @(posedge clk) begin
        if (in_i.valid) begin
            sum_q <= sum_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            first_q <= 1'b1;
            we_q    <= 1'b0;
        end else begin
            we_q <= in_i.valid & in_i.last;
            if (in_i.valid) begin
                first_q <= in_i.last;
            end
        end
    end

    // row sum and its address, held for the write cycle
    always_ff @(posedge clk) begin
        if (in_i.valid & in_i.last) begin
            addr_q <= in_i.row;
            data_q <= sum_nxt;
        end
    end

    assign res_we_o   = we_q;
    assign res_addr_o = addr_q;
    assign res_data_o = data_q;

endmodule

//--- mv_engine_top.sv
`timescale 1ns/1ns

module mv_engine_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mat_we_i,
    input  logic [mv_pkg::MAT_AW-1:0] mat_waddr_i,
    input  mv_pkg::elem_t             mat_wdata_i,
    input  logic                      vec_we_i,
    input  mv_pkg::idx_t              vec_waddr_i,
    input  mv_pkg::elem_t             vec_wdata_i,
    input  logic                      src_v_i,
    input  mv_pkg::job_t              job_i,
    input  mv_pkg::idx_t              res_raddr_i,
    output mv_pkg::acc_t              res_rdata_o,
    output logic                      exec_o,
    output logic                      k_fin_o,
    output logic                      s_fin_o
);

    mv_pkg::idx_t    row_idx;
    mv_pkg::idx_t    col_idx;
    logic            last_j;
    logic            exec;
    mv_pkg::elem_t   mat_rdata;
    mv_pkg::elem_t   vec_rdata;
    // controller outputs delayed to meet the ram read data
    logic            valid_q;
    logic            last_q;
    mv_pkg::idx_t    row_q;
    mv_pkg::mac_in_t mac_in;
    logic            res_we;
    mv_pkg::idx_t    res_waddr;
    mv_pkg::acc_t    res_wdata;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    exe_ctrl exe_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .src_v_i  (src_v_i),
        .job_i    (job_i),
        .i_o      (row_idx),
        .j_o      (col_idx),
        .last_j_o (last_j),
        .exec_o   (exec),
        .k_fin_o  (k_fin_o),
        .s_fin_o  (s_fin_o)
    );

    assign exec_o = exec;

    //////////////////////////////////////////////////////////////////////
    // operand memories
    //////////////////////////////////////////////////////////////////////

    // row index in the upper address bits
    operand_ram #(
        .T  (mv_pkg::elem_t),
        .AW (mv_pkg::MAT_AW)
    ) mat_ram_i (
        .clk     (clk),
        .we_i    (mat_we_i),
        .waddr_i (mat_waddr_i),
        .wdata_i (mat_wdata_i),
        .raddr_i ({row_idx, col_idx}),
        .rdata_o (mat_rdata)
    );

    operand_ram #(
        .T  (mv_pkg::elem_t),
        .AW (mv_pkg::IDX_W)
    ) vec_ram_i (
        .clk     (clk),
        .we_i    (vec_we_i),
        .waddr_i (vec_waddr_i),
        .wdata_i (vec_wdata_i),
        .raddr_i (col_idx),
        .rdata_o (vec_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // alignment with the read latency
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= exec;
            last_q  <= last_j;
        end
    end

    always_ff @(posedge clk) begin
        row_q <= row_idx;
    end

    always_comb begin
        mac_in.valid = valid_q;
        mac_in.last  = last_q;
        mac_in.row   = row_q;
        mac_in.a     = mat_rdata;
        mac_in.b     = vec_rdata;
    end

    //////////////////////////////////////////////////////////////////////
    // mac lane and results
    //////////////////////////////////////////////////////////////////////

    mac_lane mac_lane_i (
        .clk        (clk),
        .rst        (rst),
        .in_i       (mac_in),
        .res_we_o   (res_we),
        .res_addr_o (res_waddr),
        .res_data_o (res_wdata)
    );

    // one sum per row, read back by the host
    operand_ram #(
        .T  (mv_pkg::acc_t),
        .AW (mv_pkg::IDX_W)
    ) res_ram_i (
        .clk     (clk),
        .we_i    (res_we),
        .waddr_i (res_waddr),
        .wdata_i (res_wdata),
        .raddr_i (res_raddr_i),
        .rdata_o (res_rdata_o)
    );

endmodule

//--- tb_mv_engine.sv
`timescale 1ns/1ns

module tb_mv_engine;

    localparam logic [31:0] SEED = 32'hce106fe3;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      mat_we_i;
    logic [mv_pkg::MAT_AW-1:0] mat_waddr_i;
    mv_pkg::elem_t             mat_wdata_i;
    logic                      vec_we_i;
    mv_pkg::idx_t              vec_waddr_i;
    mv_pkg::elem_t             vec_wdata_i;
    logic                      src_v_i;
    mv_pkg::job_t              job_i;
    mv_pkg::idx_t              res_raddr_i;
    mv_pkg::acc_t              res_rdata_o;
    logic                      exec_o;
    logic                      k_fin_o;
    logic                      s_fin_o;

    // golden file contents, in file order
    byte op_kind[$];
    int  op_a[$];
    int  op_b[$];
    // expected rows of the job being run
    int  exp_row[$];
    int  exp_val[$];
    int  cycles = 0;
    int  limit = 20;

    mv_engine_top mv_engine_top_i (
        .clk         (clk),
        .rst         (rst),
        .mat_we_i    (mat_we_i),
        .mat_waddr_i (mat_waddr_i),
        .mat_wdata_i (mat_wdata_i),
        .vec_we_i    (vec_we_i),
        .vec_waddr_i (vec_waddr_i),
        .vec_wdata_i (vec_wdata_i),
        .src_v_i     (src_v_i),
        .job_i       (job_i),
        .res_raddr_i (res_raddr_i),
        .res_rdata_o (res_rdata_o),
        .exec_o      (exec_o),
        .k_fin_o     (k_fin_o),
        .s_fin_o     (s_fin_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Test failures found");
            $fatal(1, "simulation ran past the cycle limit of %0d", limit);
        end
    end

    task automatic check(input longint got, input longint exp, input string msg);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic push_op(input byte kind, input int a, input int b);
        op_kind.push_back(kind);
        op_a.push_back(a);
        op_b.push_back(b);
    endtask

    //////////////////////////////////////////////////////////////////////
    // golden file parsing
    //////////////////////////////////////////////////////////////////////

    task automatic read_golden();
        int    fd;
        byte   tag;
        int    a;
        int    b;
        int    n;
        int    v;
        string line;
        fd = $fopen("mv_engine_golden.txt", "r");
        if (fd == 0) begin
            $display("Test failures found");
            $fatal(1, "cannot open mv_engine_golden.txt");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": void'($fgets(line, fd));
                "J": begin
                    void'($fscanf(fd, " %d %d", a, b));
                    push_op("J", a, b);
                    limit += (a + 1) * (b + 1) + 40;
                end
                "M", "R": begin
                    void'($fscanf(fd, " %h %d", a, n));
                    for (int k = 0; k < n; k++) begin
                        void'($fscanf(fd, " %d", v));
                        push_op(tag, a + k, v);
                        limit += (tag == "R") ? 2 : 1;
                    end
                end
                "V": begin
                    void'($fscanf(fd, " %d", n));
                    for (int k = 0; k < n; k++) begin
                        void'($fscanf(fd, " %d", v));
                        push_op("V", k, v);
                        limit += 1;
                    end
                end
                default: begin
                    $display("Test failures found");
                    $fatal(1, "unknown line tag in golden file");
                end
            endcase
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // job execution
    //////////////////////////////////////////////////////////////////////

    task automatic run_job(input int rows_m1, input int cols_m1);
        int n;
        int gap;
        bit kfin_exp;
        n = (rows_m1 + 1) * (cols_m1 + 1);
        gap = $urandom % 8;
        @(posedge clk);
        mat_we_i <= 1'b0;
        vec_we_i <= 1'b0;
        repeat (gap) @(posedge clk);
        // cycle 0 of the job
        @(posedge clk);
        src_v_i <= 1'b1;
        job_i.rows_m1 <= mv_pkg::idx_t'(rows_m1);
        job_i.cols_m1 <= mv_pkg::idx_t'(cols_m1);
        for (int c = 1; c <= n + 2; c++) begin
            @(posedge clk);
            src_v_i <= 1'b0;
            @(negedge clk);
            check(exec_o, c <= n, "exec_o");
            kfin_exp = (c > 1) && (c <= n + 1) && ((c - 1) % (cols_m1 + 1) == 0);
            check(k_fin_o, kfin_exp, "k_fin_o");
            check(s_fin_o, c == n + 2, "s_fin_o");
        end
        for (int k = 0; k < exp_row.size(); k++) begin
            @(posedge clk);
            res_raddr_i <= mv_pkg::idx_t'(exp_row[k]);
            @(posedge clk);
            @(negedge clk);
            check(res_rdata_o, exp_val[k], $sformatf("result of row %0d", exp_row[k]));
        end
        exp_row.delete();
        exp_val.delete();
    endtask

    task automatic run_ops();
        bit pending;
        int rows_m1;
        int cols_m1;
        pending = 1'b0;
        rows_m1 = 0;
        cols_m1 = 0;
        for (int i = 0; i < op_kind.size(); i++) begin
            case (op_kind[i])
                "J": begin
                    if (pending) begin
                        run_job(rows_m1, cols_m1);
                    end
                    rows_m1 = op_a[i];
                    cols_m1 = op_b[i];
                    pending = 1'b1;
                end
                "M": begin
                    @(posedge clk);
                    vec_we_i    <= 1'b0;
                    mat_we_i    <= 1'b1;
                    mat_waddr_i <= op_a[i][mv_pkg::MAT_AW-1:0];
                    mat_wdata_i <= mv_pkg::elem_t'(op_b[i]);
                end
                "V": begin
                    @(posedge clk);
                    mat_we_i    <= 1'b0;
                    vec_we_i    <= 1'b1;
                    vec_waddr_i <= mv_pkg::idx_t'(op_a[i]);
                    vec_wdata_i <= mv_pkg::elem_t'(op_b[i]);
                end
                default: begin
                    exp_row.push_back(op_a[i]);
                    exp_val.push_back(op_b[i]);
                end
            endcase
        end
        if (pending) begin
            run_job(rows_m1, cols_m1);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        mat_we_i    = 1'b0;
        mat_waddr_i = '0;
        mat_wdata_i = '0;
        vec_we_i    = 1'b0;
        vec_waddr_i = '0;
        vec_wdata_i = '0;
        src_v_i     = 1'b0;
        job_i       = '0;
        res_raddr_i = '0;
        read_golden();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        run_ops();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- mv_engine_golden.txt
# J rows_m1 cols_m1 | M base_addr_hex count elems | V count elems | R first_row count sums
# elements and sums in signed decimal, matrix address is {row, col}
J 0 0
M 00 1 -7
V 1 9
R 0 1 -63
J 15 15
M 00 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 10 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 20 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 30 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 40 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 50 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 60 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 70 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 80 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M 90 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M a0 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M b0 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M c0 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M d0 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M e0 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
M f0 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
V 16 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
R 0 8 262144 262144 262144 262144 262144 262144 262144 262144
R 8 8 262144 262144 262144 262144 262144 262144 262144 262144
J 15 0
V 1 3
R 0 8 -384 -384 -384 -384 -384 -384 -384 -384
R 8 8 -384 -384 -384 -384 -384 -384 -384 -384
J 15 15
M 00 16 1 -1 1 -1 1 -1 1 -1 1 -1 1 -1 1 -1 1 -1
M 10 16 -128 127 -128 127 -128 127 -128 127 -128 127 -128 127 -128 127 -128 127
V 16 1 -1 2 -2 3 -3 4 -4 5 -5 6 -6 7 -7 127 -128
R 0 8 311 -39652 128 128 128 128 128 128
R 8 8 128 128 128 128 128 128 128 128
J 4 3
M 00 4 1 2 3 4
M 10 4 -1 -1 -1 -1
M 20 4 10 0 -10 7
M 30 4 -128 127 0 0
M 40 4 50 50 50 50
V 4 2 -3 5 1
R 0 5 15 -5 -23 -637 250
J 2 3
M 00 4 3 3 3 3
M 10 4 0 -5 9 8
M 20 4 100 -100 1 -1
V 4 -2 1 0 3
R 0 5 6 19 -303 -637 250

//--- sources.f
mv_pkg.sv
agu_next.sv
exe_ctrl.sv
operand_ram.sv
mac_lane.sv
mv_engine_top.sv
tb_mv_engine.sv

//--- Makefile
SIM := obj_dir/Vtb_mv_engine

.PHONY: compile run clean

compile: $(SIM)

$(SIM): sources.f *.sv
	verilator --binary --timing -Wno-fatal --top-module tb_mv_engine -f sources.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
